// File: sim.f
src/rlwe_mem_pkg.sv
src/rlwe_isa_pkg.sv
src/rlwe_instr_queue.sv
src/rlwe_decode.sv
src/rlwe_execute.sv
src/rlwe_result.sv
src/rlwe_tcm.sv
src/rlwe_top.sv
tb/tb_rlwe_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the RLWE coprocessor testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module tb_rlwe_top -f sim.f -o tb_rlwe_top
./obj_dir/tb_rlwe_top 2>&1 | tee "$LOG"

if grep -q "^Test passed$" "$LOG"; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

// File: tb/tb_rlwe_top.sv
// Directed testbench for rlwe_top with its default parameters
// The local model assumes the DUT defaults MODULUS 12289 and QUEUE_DEPTH 4
// Inputs change 5 time units after the rising edge and outputs are sampled there too
`default_nettype none

module tb_rlwe_top;

    import rlwe_mem_pkg::*;
    import rlwe_isa_pkg::*;

    localparam int     QUEUE_DEPTH  = 4;
    localparam int     MODULUS      = 12289;
    localparam longint MOD_L        = MODULUS;
    localparam int     HALF_PERIOD  = 20;
    localparam int     DRIVE_DELAY  = 5;
    localparam int     RESET_CYCLES = 10;

    // --------------------
    // Cycle budget
    // --------------------
    localparam int SCAN_CYCLES     = 2**ADDR_W + 4;      // Full TCM read-back or fill
    localparam int NUM_SCANS       = 12;
    localparam int INSTR_CYCLES    = 2 + 16 + 3 + 12;    // Longest vector plus slack
    localparam int NUM_INSTRS      = 16;
    localparam int PUSH_WAIT_LIMIT = QUEUE_DEPTH * INSTR_CYCLES;
    localparam int BUDGET_CYCLES   = RESET_CYCLES + NUM_SCANS * SCAN_CYCLES +
                                     NUM_INSTRS * (INSTR_CYCLES + 2 * 16) + 100;

    logic               clk;
    logic               rst_n_out;
    logic               i_instr_valid;
    rlwe_instr_t        i_instr;
    logic               o_credit;
    host_req_t          i_dmem;
    logic               o_dmem_rvalid;
    logic [COEF_W-1:0]  o_dmem_rdata;
    logic               o_idle;
    logic               o_illegal;

    logic [COEF_W-1:0]  model_mem [2**ADDR_W];  // Expected TCM contents
    logic [31:0]        lfsr_state;
    int                 pushes;
    int                 credits_back;

    rlwe_top i_dut (
        .clk           (clk           ),
        .rst_n_out     (rst_n_out     ),
        .i_instr_valid (i_instr_valid ),
        .i_instr       (i_instr       ),
        .o_credit      (o_credit      ),
        .i_dmem        (i_dmem        ),
        .o_dmem_rvalid (o_dmem_rvalid ),
        .o_dmem_rdata  (o_dmem_rdata  ),
        .o_idle        (o_idle        ),
        .o_illegal     (o_illegal     )
    );

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Counts returned credits just after each edge
    initial begin
        credits_back = 0;
        forever begin
            @(posedge clk);
            #1;
            if (rst_n_out && o_credit) credits_back++;
        end
    end

    initial begin
        repeat (BUDGET_CYCLES) @(posedge clk);
        fail_run($sformatf("Run did not finish within %0d cycles", BUDGET_CYCLES));
    end

    // --------------------
    // Reporting and compare
    // --------------------
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_coef(input string name, input logic [COEF_W-1:0] got,
                              input logic [COEF_W-1:0] exp);
        if (got !== exp) fail_run($sformatf("FAILED %s: got 0x%04h, expected 0x%04h",
                                            name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) fail_run($sformatf("FAILED %s: got 0x%0h, expected 0x%0h",
                                            name, got, exp));
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) fail_run($sformatf("FAILED %s: got 0x%0h, expected 0x%0h",
                                           name, got, exp));
    endtask

    // --------------------
    // Stimulus and model
    // --------------------
    // Fibonacci LFSR with taps 32 22 2 1 and one step per bit taken
    function automatic logic [31:0] rand_bits(input int nbits);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < nbits; k++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [COEF_W-1:0] rand_coef();
        return COEF_W'(rand_bits(COEF_W) % MODULUS);
    endfunction

    function automatic logic [COEF_W-1:0] mod_result(input logic [OPC_W-1:0] opc,
                                                     input logic [COEF_W-1:0] a,
                                                     input logic [COEF_W-1:0] b);
        longint r;
        case (opc)
            OP_ADD:  r = (longint'(a) + longint'(b)) % MOD_L;
            OP_SUB:  r = (longint'(a) - longint'(b) + MOD_L) % MOD_L;   // Never negative
            OP_MUL:  r = (longint'(a) * longint'(b)) % MOD_L;
            default: r = 0;
        endcase
        return COEF_W'(r);
    endfunction

    function automatic rlwe_instr_t make_instr(input logic [OPC_W-1:0] opc, input int len,
                                               input logic [ADDR_W-1:0] s1,
                                               input logic [ADDR_W-1:0] s2,
                                               input logic [ADDR_W-1:0] d);
        rlwe_instr_t ins;
        ins.opcode = opc;
        ins.len    = LEN_W'(len - 1);
        ins.src2   = s2;
        ins.src1   = s1;
        ins.dst    = d;
        return ins;
    endfunction

    // Illegal opcodes leave the model untouched
    task automatic model_exec(input rlwe_instr_t ins);
        logic [ADDR_W-1:0] a1;
        logic [ADDR_W-1:0] a2;
        logic [ADDR_W-1:0] ad;
        if (ins.opcode == OP_ADD || ins.opcode == OP_SUB || ins.opcode == OP_MUL) begin
            for (int i = 0; i <= int'(ins.len); i++) begin
                a1 = ins.src1 + ADDR_W'(i);     // Wraps at 256
                a2 = ins.src2 + ADDR_W'(i);
                ad = ins.dst + ADDR_W'(i);
                model_mem[ad] = mod_result(ins.opcode, model_mem[a1], model_mem[a2]);
            end
        end
    endtask

    task automatic host_write(input logic [ADDR_W-1:0] addr, input logic [COEF_W-1:0] data);
        i_dmem = '{valid: 1'b1, write: 1'b1, addr: addr, wdata: data};
        @(posedge clk);
        #DRIVE_DELAY;
        i_dmem = '0;
        model_mem[addr] = data;
    endtask

    // Response is due exactly one cycle after the request
    task automatic host_read_check(input logic [ADDR_W-1:0] addr,
                                   input logic [COEF_W-1:0] exp);
        i_dmem = '{valid: 1'b1, write: 1'b0, addr: addr, wdata: '0};
        @(posedge clk);
        #DRIVE_DELAY;
        i_dmem = '0;
        check_bit("o_dmem_rvalid", o_dmem_rvalid, 1'b1);
        check_coef($sformatf("o_dmem_rdata[%02h]", addr), o_dmem_rdata, exp);
    endtask

    task automatic check_all();
        for (int a = 0; a < 2**ADDR_W; a++) host_read_check(ADDR_W'(a), model_mem[a]);
    endtask

    // Pushes only while a credit is held
    task automatic push_instr(input rlwe_instr_t ins);
        int waited;
        waited = 0;
        while (QUEUE_DEPTH - pushes + credits_back == 0) begin
            if (waited == PUSH_WAIT_LIMIT) fail_run("No credit came back for the next push");
            @(posedge clk);
            #DRIVE_DELAY;
            waited++;
        end
        i_instr_valid = 1'b1;
        i_instr       = ins;
        pushes++;
        @(posedge clk);
        #DRIVE_DELAY;
        i_instr_valid = 1'b0;
        check_bit("o_idle", o_idle, 1'b0);      // Queue holds the new entry
    endtask

    task automatic wait_idle(input int max_cycles);
        int n;
        n = 0;
        while (!o_idle) begin
            if (n == max_cycles) fail_run("The coprocessor did not return to idle in time");
            @(posedge clk);
            #DRIVE_DELAY;
            n++;
        end
    endtask

    task automatic run_vector(input logic [OPC_W-1:0] opc, input logic [ADDR_W-1:0] s1,
                              input logic [ADDR_W-1:0] s2, input logic [ADDR_W-1:0] d);
        rlwe_instr_t ins;
        int          len;
        len = int'(rand_bits(LEN_W)) + 1;       // 1 to 16 elements
        for (int i = 0; i < len; i++) begin
            host_write(s1 + ADDR_W'(i), rand_coef());
            host_write(s2 + ADDR_W'(i), rand_coef());
        end
        ins = make_instr(opc, len, s1, s2, d);
        push_instr(ins);
        wait_idle(INSTR_CYCLES);
        model_exec(ins);
        check_all();
    endtask

    // --------------------
    // Tests
    // --------------------
    task automatic test_reset_state();
        @(posedge clk);
        #DRIVE_DELAY;
        check_bit("o_credit", o_credit, 1'b0);
        check_bit("o_illegal", o_illegal, 1'b0);
        check_bit("o_idle", o_idle, 1'b1);
        check_bit("o_dmem_rvalid", o_dmem_rvalid, 1'b0);
    endtask

    task automatic test_host_rw();
        for (int a = 0; a < 2**ADDR_W; a++) begin
            host_write(ADDR_W'(a), COEF_W'((a * 97 + 13) % MODULUS));
        end
        check_bit("o_dmem_rvalid", o_dmem_rvalid, 1'b0);    // Writes give no response
        host_read_check(8'h5a, model_mem[8'h5a]);
        @(posedge clk);
        #DRIVE_DELAY;
        check_bit("o_dmem_rvalid", o_dmem_rvalid, 1'b0);
        check_all();
    endtask

    task automatic test_vectors();
        run_vector(OP_ADD, 8'h20, 8'h40, 8'h60);
        run_vector(OP_SUB, 8'h20, 8'h40, 8'h60);
        run_vector(OP_MUL, 8'h20, 8'h40, 8'h60);
        // Source range crosses the top of the TCM
        run_vector(OP_ADD, 8'hf4, 8'h30, 8'h70);
        run_vector(OP_SUB, 8'hf4, 8'h30, 8'h70);
        run_vector(OP_MUL, 8'hf4, 8'h30, 8'h70);
    endtask

    task automatic test_credits();
        rlwe_instr_t ins [QUEUE_DEPTH];
        int          back_before;
        check_count("credits held", QUEUE_DEPTH - pushes + credits_back, QUEUE_DEPTH);
        for (int i = 0; i < 4; i++) begin
            host_write(8'h10 + ADDR_W'(i), rand_coef());
            host_write(8'h40 + ADDR_W'(i), rand_coef());
        end
        ins[0] = make_instr(OP_ADD, 4, 8'h10, 8'h40, 8'h90);
        ins[1] = make_instr(OP_SUB, 4, 8'h10, 8'h40, 8'ha0);
        ins[2] = make_instr(OP_MUL, 4, 8'h10, 8'h40, 8'hb0);
        ins[3] = make_instr(OP_ADD, 4, 8'h10, 8'h40, 8'hc0);
        back_before = credits_back;
        for (int k = 0; k < QUEUE_DEPTH; k++) push_instr(ins[k]);   // Back to back
        wait_idle(PUSH_WAIT_LIMIT);
        check_count("credit pulses", credits_back - back_before, QUEUE_DEPTH);
        for (int k = 0; k < QUEUE_DEPTH; k++) model_exec(ins[k]);
        check_all();
    endtask

    task automatic test_illegal();
        check_bit("o_illegal", o_illegal, 1'b0);            // Legal work leaves it clear
        push_instr(make_instr(4'hf, 4, 8'h20, 8'h40, 8'ha0));
        wait_idle(INSTR_CYCLES);
        check_bit("o_illegal", o_illegal, 1'b1);
        check_all();
        run_vector(OP_SUB, 8'h24, 8'h44, 8'ha0);
        check_bit("o_illegal", o_illegal, 1'b1);            // Sticky
    endtask

    initial begin
        rst_n_out     = 1'b0;
        i_instr_valid = 1'b0;
        i_instr       = '0;
        i_dmem        = '0;
        lfsr_state    = 32'hc5a6ee84;
        pushes        = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n_out = 1'b1;
        test_reset_state();
        test_host_rw();
        test_vectors();
        test_credits();
        test_illegal();
        run_vector(OP_MUL, 8'h60, 8'h34, 8'h60);            // In-place MUL with dst equal to src1
        $display("Test passed");
        $finish;
    end

endmodule : tb_rlwe_top

`default_nettype wire

// File: src/rlwe_top.sv
// RLWE coprocessor: instruction queue, decode, execute, result and TCM
// Instruction flow control is credit based, QUEUE_DEPTH credits after reset
// Host data reads return one cycle after the request, writes give no response
`default_nettype none

module rlwe_top #(
    parameter int QUEUE_DEPTH = 4,
    parameter int MODULUS     = 12289
) (
    input  wire                                  clk,
    input  wire                                  rst_n_out,
    // Instruction side
    input  wire                                  i_instr_valid,
    input  wire rlwe_isa_pkg::rlwe_instr_t       i_instr,
    output logic                                 o_credit,
    // Host data side
    input  wire rlwe_mem_pkg::host_req_t         i_dmem,
    output logic                                 o_dmem_rvalid,
    output logic [rlwe_mem_pkg::COEF_W-1:0]      o_dmem_rdata,
    // Status
    output logic                                 o_idle,
    output logic                                 o_illegal
);

    import rlwe_mem_pkg::*;
    import rlwe_isa_pkg::*;

    rlwe_instr_t        q_head;
    logic               q_empty;
    logic               dec_pop;
    coef_op_t           coef_op;
    logic [COEF_W-1:0]  rdata_a;
    logic [COEF_W-1:0]  rdata_b;
    wb_t                exe_wb;
    wb_t                tcm_wr;
    logic               retire;
    logic               illegal_stb;

    rlwe_instr_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) i_queue (
        .clk           (clk             ),
        .rst_n_out     (rst_n_out       ),
        .i_push        (i_instr_valid   ),
        .i_data        (i_instr         ),
        .i_pop         (dec_pop         ),
        .o_head        (q_head          ),
        .o_empty       (q_empty         ),
        .o_credit      (o_credit        )
    );

    rlwe_decode i_decode (
        .clk           (clk             ),
        .rst_n_out     (rst_n_out       ),
        .i_head        (q_head          ),
        .i_empty       (q_empty         ),
        .o_pop         (dec_pop         ),
        .i_retire      (retire          ),
        .o_op          (coef_op         ),
        .o_illegal_stb (illegal_stb     ),
        .o_idle        (o_idle          )
    );

    rlwe_execute #(.MODULUS(MODULUS)) i_execute (
        .clk           (clk             ),
        .rst_n_out     (rst_n_out       ),
        .i_op          (coef_op         ),
        .i_rdata_a     (rdata_a         ),
        .i_rdata_b     (rdata_b         ),
        .o_wb          (exe_wb          )
    );

    rlwe_result i_result (
        .clk           (clk             ),
        .rst_n_out     (rst_n_out       ),
        .i_wb          (exe_wb          ),
        .i_illegal_stb (illegal_stb     ),
        .o_tcm_wr      (tcm_wr          ),
        .o_retire      (retire          ),
        .o_illegal     (o_illegal       )
    );

    // Operand addresses go straight from decode to the TCM read ports
    rlwe_tcm i_tcm (
        .clk           (clk             ),
        .rst_n_out     (rst_n_out       ),
        .i_host        (i_dmem          ),
        .o_host_rvalid (o_dmem_rvalid   ),
        .o_host_rdata  (o_dmem_rdata    ),
        .i_raddr_a     (coef_op.src1    ),
        .i_raddr_b     (coef_op.src2    ),
        .o_rdata_a     (rdata_a         ),
        .o_rdata_b     (rdata_b         ),
        .i_wr          (tcm_wr          )
    );

endmodule : rlwe_top

`default_nettype wire

// File: src/rlwe_tcm.sv
// 256-word coefficient memory, contents not reset
// Reads are registered and return the old word on a same-address write
// The host write wins over a coprocessor write to the same address
`default_nettype none

module rlwe_tcm (
    input  wire                                  clk,
    input  wire                                  rst_n_out,
    input  wire rlwe_mem_pkg::host_req_t         i_host,
    output logic                                 o_host_rvalid,
    output logic [rlwe_mem_pkg::COEF_W-1:0]      o_host_rdata,
    input  wire [rlwe_mem_pkg::ADDR_W-1:0]       i_raddr_a,
    input  wire [rlwe_mem_pkg::ADDR_W-1:0]       i_raddr_b,
    output logic [rlwe_mem_pkg::COEF_W-1:0]      o_rdata_a,
    output logic [rlwe_mem_pkg::COEF_W-1:0]      o_rdata_b,
    input  wire rlwe_mem_pkg::wb_t               i_wr
);

    import rlwe_mem_pkg::*;

    logic [COEF_W-1:0] mem [2**ADDR_W];
    logic              host_wr;
    logic              host_rd;

    assign host_wr = i_host.valid && i_host.write;
    assign host_rd = i_host.valid && !i_host.write;

    // Write ports, host last so it takes priority
    always_ff @(posedge clk) begin
        if (i_wr.valid) begin
            mem[i_wr.addr] <= i_wr.data;
        end
        if (host_wr) begin
            mem[i_host.addr] <= i_host.wdata;
        end
    end

    // --------------------
    // Read ports
    // --------------------
    always_ff @(posedge clk) begin
        o_rdata_a    <= mem[i_raddr_a];        // Coprocessor operands
        o_rdata_b    <= mem[i_raddr_b];
        o_host_rdata <= mem[i_host.addr];
    end

    always_ff @(posedge clk) begin
        if (!rst_n_out) o_host_rvalid <= 1'b0;
        else            o_host_rvalid <= host_rd;  // One cycle after the request
    end

endmodule : rlwe_tcm

`default_nettype wire

// File: src/rlwe_result.sv
// Write-back stage. Each write to the TCM retires one coefficient operation
// The illegal flag is sticky and cleared only by reset
`default_nettype none

module rlwe_result (
    input  wire                              clk,
    input  wire                              rst_n_out,
    input  wire rlwe_mem_pkg::wb_t           i_wb,
    input  wire                              i_illegal_stb,
    output rlwe_mem_pkg::wb_t                o_tcm_wr,
    output logic                             o_retire,
    output logic                             o_illegal
);

    logic illegal_q;

    // --------------------
    // Write-back and retire
    // --------------------
    // The write lands at the same edge that decode sees the retire, so a
    // following instruction never reads a stale word
    assign o_tcm_wr = i_wb;
    assign o_retire = i_wb.valid;               // One pulse per word written

    // --------------------
    // Sticky status
    // --------------------
    always_ff @(posedge clk) begin
        if (!rst_n_out) begin
            illegal_q <= 1'b0;
        end else if (i_illegal_stb) begin
            illegal_q <= 1'b1;
        end
    end

    assign o_illegal = illegal_q;

endmodule : rlwe_result

`default_nettype wire

// File: src/rlwe_execute.sv
// Modular ADD, SUB and MUL on TCM operands. Operands must be below MODULUS,
// and MODULUS must be below 2^15. One result per cycle, registered
`default_nettype none

module rlwe_execute #(
    parameter int MODULUS = 12289
) (
    input  wire                                  clk,
    input  wire                                  rst_n_out,
    input  wire rlwe_isa_pkg::coef_op_t          i_op,
    input  wire [rlwe_mem_pkg::COEF_W-1:0]       i_rdata_a,
    input  wire [rlwe_mem_pkg::COEF_W-1:0]       i_rdata_b,
    output rlwe_mem_pkg::wb_t                    o_wb
);

    import rlwe_mem_pkg::*;
    import rlwe_isa_pkg::*;

    localparam logic [COEF_W:0]     MOD_EXT  = (COEF_W + 1)'(MODULUS);
    localparam logic [2*COEF_W-1:0] MOD_PROD = (2 * COEF_W)'(MODULUS);

    logic                   op_vld_q;
    coef_op_t               op_q;               // Lines up with the TCM read data
    logic [COEF_W:0]        sum;
    logic [COEF_W:0]        diff;
    logic [2*COEF_W-1:0]    prod;
    logic [COEF_W-1:0]      res;
    logic                   wb_vld_q;
    logic [ADDR_W-1:0]      wb_addr_q;
    logic [COEF_W-1:0]      wb_data_q;

    always_ff @(posedge clk) begin
        if (!rst_n_out) op_vld_q <= 1'b0;
        else            op_vld_q <= i_op.valid;
    end

    always_ff @(posedge clk) begin
        op_q <= i_op;
    end

    assign sum  = {1'b0, i_rdata_a} + {1'b0, i_rdata_b};
    assign diff = {1'b0, i_rdata_a} - {1'b0, i_rdata_b} +
                  ((i_rdata_a < i_rdata_b) ? MOD_EXT : '0);   // Keep it non-negative
    assign prod = i_rdata_a * i_rdata_b;

    always_comb begin
        case (op_q.op)
            OP_ADD:  res = (sum >= MOD_EXT) ? COEF_W'(sum - MOD_EXT) : COEF_W'(sum);
            OP_SUB:  res = COEF_W'(diff);
            OP_MUL:  res = COEF_W'(prod % MOD_PROD);
            default: res = '0;
        endcase
    end

    // Result stage
    always_ff @(posedge clk) begin
        if (!rst_n_out) wb_vld_q <= 1'b0;
        else            wb_vld_q <= op_vld_q;
    end

    always_ff @(posedge clk) begin
        wb_addr_q <= op_q.dst;
        wb_data_q <= res;
    end

    assign o_wb = '{valid: wb_vld_q, addr: wb_addr_q, data: wb_data_q};

    // Reduced results stay in range as long as the host loaded reduced operands
    a_result_reduced : assert property (@(posedge clk) disable iff (!rst_n_out)
        o_wb.valid |-> (o_wb.data < COEF_W'(MODULUS)));

endmodule : rlwe_execute

`default_nettype wire

// File: src/rlwe_decode.sv
// Expands one vector instruction into len+1 coefficient operations, one per cycle
// A new instruction starts only once every operation of the previous one is written
// Illegal opcodes are dequeued, flagged and otherwise dropped
`default_nettype none

module rlwe_decode (
    input  wire                              clk,
    input  wire                              rst_n_out,
    input  wire rlwe_isa_pkg::rlwe_instr_t   i_head,
    input  wire                              i_empty,
    output logic                             o_pop,
    input  wire                              i_retire,
    output rlwe_isa_pkg::coef_op_t           o_op,
    output logic                             o_illegal_stb,
    output logic                             o_idle
);

    import rlwe_mem_pkg::*;
    import rlwe_isa_pkg::*;

    typedef enum logic [1:0] {
        DEC_IDLE,
        DEC_EXPAND,
        DEC_DRAIN
    } dec_state_e;

    dec_state_e         state;
    opcode_e            cur_opc;
    logic [ADDR_W-1:0]  cur_src1;
    logic [ADDR_W-1:0]  cur_src2;
    logic [ADDR_W-1:0]  cur_dst;
    logic [LEN_W-1:0]   cur_len;
    logic [LEN_W-1:0]   idx;                    // Element being issued
    logic [2:0]         inflight;               // Issued but not yet written
    logic               start;
    logic               issue;

    assign start         = (state == DEC_IDLE) && !i_empty && (inflight == '0);
    assign issue         = (state == DEC_EXPAND);
    assign o_pop         = start;
    assign o_illegal_stb = start && !is_legal_op(i_head.opcode);
    assign o_idle        = (state == DEC_IDLE) && i_empty && (inflight == '0);

    // Addresses wrap at the top of the TCM
    assign o_op = '{valid: issue,
                    op:    cur_opc,
                    src1:  cur_src1 + ADDR_W'(idx),
                    src2:  cur_src2 + ADDR_W'(idx),
                    dst:   cur_dst  + ADDR_W'(idx)};

    // --------------------
    // FSM
    // --------------------
    always_ff @(posedge clk) begin
        if (!rst_n_out) begin
            state <= DEC_IDLE;
        end else begin
            case (state)
                DEC_IDLE:   if (start && is_legal_op(i_head.opcode)) state <= DEC_EXPAND;
                DEC_EXPAND: if (idx == cur_len) state <= DEC_DRAIN;
                DEC_DRAIN:  if (inflight == '0) state <= DEC_IDLE;
                default:    state <= DEC_IDLE;
            endcase
        end
    end

    // Instruction fields, latched at dequeue
    always_ff @(posedge clk) begin
        if (start) begin
            cur_opc  <= opcode_e'(i_head.opcode);
            cur_len  <= i_head.len;
            cur_src1 <= i_head.src1;
            cur_src2 <= i_head.src2;
            cur_dst  <= i_head.dst;
            idx      <= '0;
        end else if (issue) begin
            idx <= idx + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_out) begin
            inflight <= '0;
        end else begin
            case ({issue, i_retire})
                2'b10:   inflight <= inflight + 1'b1;
                2'b01:   inflight <= inflight - 1'b1;
                default: inflight <= inflight;   // Both or neither
            endcase
        end
    end

    // Every retire from the result stage matches an earlier issue
    a_inflight_no_underflow : assert property (@(posedge clk) disable iff (!rst_n_out)
        i_retire |-> (inflight != '0));

endmodule : rlwe_decode

`default_nettype wire

// File: src/rlwe_instr_queue.sv
// Instruction FIFO with credit return. QUEUE_DEPTH must be a power of two, 2 or more
// The host owns QUEUE_DEPTH credits after reset and may push only while holding one
// A credit pulse follows each dequeue by one cycle
`default_nettype none

module rlwe_instr_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  wire                              clk,
    input  wire                              rst_n_out,
    input  wire                              i_push,
    input  wire rlwe_isa_pkg::rlwe_instr_t   i_data,
    input  wire                              i_pop,
    output rlwe_isa_pkg::rlwe_instr_t        o_head,
    output logic                             o_empty,
    output logic                             o_credit
);

    import rlwe_isa_pkg::*;

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    logic [INSTR_W-1:0] mem [QUEUE_DEPTH];
    logic [PTR_W:0]     wr_ptr;                 // Extra MSB tells full from empty
    logic [PTR_W:0]     rd_ptr;
    logic               full;
    logic               wr_en;
    logic               rd_en;

    assign o_empty = (wr_ptr == rd_ptr);
    assign full    = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                     (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);
    assign wr_en   = i_push && !full;
    assign rd_en   = i_pop && !o_empty;
    assign o_head  = rlwe_instr_t'(mem[rd_ptr[PTR_W-1:0]]);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[PTR_W-1:0]] <= i_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_out) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            o_credit <= 1'b0;
        end else begin
            if (wr_en) wr_ptr <= wr_ptr + 1'b1;
            if (rd_en) rd_ptr <= rd_ptr + 1'b1;
            o_credit <= rd_en;                  // One credit back per dequeue
        end
    end

    // Host must never push without a credit
    a_no_push_when_full : assert property (@(posedge clk) disable iff (!rst_n_out)
        i_push |-> !full);

    // Decode only dequeues a present entry
    a_no_pop_when_empty : assert property (@(posedge clk) disable iff (!rst_n_out)
        i_pop |-> !o_empty);

endmodule : rlwe_instr_queue

`default_nettype wire

// File: src/rlwe_isa_pkg.sv
// Coprocessor instruction set: opcodes, the 32-bit instruction word and the
// per-coefficient operation. Opcodes other than ADD, SUB and MUL are illegal
`default_nettype none

package rlwe_isa_pkg;

    localparam int INSTR_W = 32;
    localparam int OPC_W   = 4;
    localparam int LEN_W   = 4;                 // Vector length minus one

    typedef enum logic [OPC_W-1:0] {
        OP_ADD = 4'h1,
        OP_SUB = 4'h2,
        OP_MUL = 4'h3
    } opcode_e;

    // --------------------
    // Instruction word, MSB first
    // --------------------
    typedef struct packed {
        logic [OPC_W-1:0]                opcode;   // Raw field, may hold illegal codes
        logic [LEN_W-1:0]                len;
        logic [rlwe_mem_pkg::ADDR_W-1:0] src2;
        logic [rlwe_mem_pkg::ADDR_W-1:0] src1;
        logic [rlwe_mem_pkg::ADDR_W-1:0] dst;
    } rlwe_instr_t;

    // One element of an expanded vector instruction, 29 bits
    typedef struct packed {
        logic                            valid;
        opcode_e                         op;
        logic [rlwe_mem_pkg::ADDR_W-1:0] src1;
        logic [rlwe_mem_pkg::ADDR_W-1:0] src2;
        logic [rlwe_mem_pkg::ADDR_W-1:0] dst;
    } coef_op_t;

    function automatic logic is_legal_op(logic [OPC_W-1:0] opc);
        return (opc == OP_ADD) || (opc == OP_SUB) || (opc == OP_MUL);
    endfunction

endpackage : rlwe_isa_pkg

`default_nettype wire

// File: src/rlwe_mem_pkg.sv
// TCM side widths and the structs that move data to and from the coefficient memory
// One TCM word holds one coefficient, 256 words in total
`default_nettype none

package rlwe_mem_pkg;

    localparam int COEF_W = 16;                 // Coefficient and TCM word width
    localparam int ADDR_W = 8;                  // 256 words

    // Host data port request, 26 bits
    typedef struct packed {
        logic                valid;
        logic                write;              // 1 = write, 0 = read
        logic [ADDR_W-1:0]   addr;
        logic [COEF_W-1:0]   wdata;
    } host_req_t;

    // Coprocessor write-back into the TCM, 25 bits
    typedef struct packed {
        logic                valid;
        logic [ADDR_W-1:0]   addr;
        logic [COEF_W-1:0]   data;
    } wb_t;

endpackage : rlwe_mem_pkg

`default_nettype wire
